// ==== Makefile ====
SIM_LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module tb_simd_alu

sim:
	verilator --binary --timing -f src.f --top-module tb_simd_alu -Mdir obj_dir
	./obj_dir/Vtb_simd_alu | tee $(SIM_LOG)
	grep -qx "Test passed" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

// ==== simd_alu_arith.sv ====
// Per-lane wrapping, saturating and averaging add/subtract with saturation flags
`timescale 1ns/1ps

module simd_alu_arith import simd_alu_pkg::*; (
  input  alu_op_e op_i,
  input  vew_e    vew_i,
  input  vxrm_e   vxrm_i,
  input  logic    signed_i,
  input  elen_t   opa_i,
  input  elen_t   opb_i,
  output elen_t   result_o,
  output strb_t   sat_o
);

  // One element of w bits, returns {saturated, result}
  function automatic logic [DataWidth:0] lane_arith(alu_op_e op, vxrm_e rm, logic sgn,
                                                    elen_t a, elen_t b, logic [6:0] w);
    logic [DataWidth:0] a_x;
    logic [DataWidth:0] b_x;
    logic [DataWidth:0] sum;
    logic [DataWidth:0] diff;
    elen_t              umax;
    elen_t              smax;
    elen_t              res;
    logic               sat;
    logic               rnd;
    a_x  = lane_ext(a, w, sgn);
    b_x  = lane_ext(b, w, sgn);
    sum  = a_x + b_x;
    diff = b_x - a_x;
    umax = ~({DataWidth{1'b1}} << w);
    smax = umax >> 1;
    sat  = 1'b0;
    res  = '0;

    // Increment from the dropped bit sum[0] and kept bit sum[1]
    case (rm)
      RNU:     rnd = sum[0];
      RNE:     rnd = sum[0] & sum[1];
      RDN:     rnd = 1'b0;
      default: rnd = sum[0] & ~sum[1];
    endcase

    case (op)
      VADD: res = sum[DataWidth-1:0];
      VSUB: res = diff[DataWidth-1:0];
      VSADDU, VSADD: begin
        sat = sgn ? (sum[w] ^ sum[w - 7'd1]) : sum[w];
        if (sat) begin
          res = sgn ? (sum[w] ? ~smax : smax) : umax;
        end else begin
          res = sum[DataWidth-1:0];
        end
      end
      VSSUBU, VSSUB: begin
        // Unsigned borrow clamps to zero
        sat = sgn ? (diff[w] ^ diff[w - 7'd1]) : diff[w];
        if (sat) begin
          res = sgn ? (diff[w] ? ~smax : smax) : '0;
        end else begin
          res = diff[DataWidth-1:0];
        end
      end
      VAADDU, VAADD: res = sum[DataWidth:1] + 64'(rnd);
      default: res = '0;
    endcase
    return {sat, res};
  endfunction

  ////////////////////////////////////////
  // Lane split by element width
  ////////////////////////////////////////

  always_comb begin
    logic [DataWidth:0] lane;
    result_o = '0;
    sat_o    = '0;
    lane     = '0;
    unique case (vew_i)
      EW8: for (int e = 0; e < 8; e++) begin
        lane = lane_arith(op_i, vxrm_i, signed_i, 64'(opa_i[e*8 +: 8]),
                          64'(opb_i[e*8 +: 8]), 7'd8);
        result_o[e*8 +: 8] = lane[7:0];
        sat_o[e]           = lane[DataWidth];
      end
      EW16: for (int e = 0; e < 4; e++) begin
        lane = lane_arith(op_i, vxrm_i, signed_i, 64'(opa_i[e*16 +: 16]),
                          64'(opb_i[e*16 +: 16]), 7'd16);
        result_o[e*16 +: 16] = lane[15:0];
        sat_o[e*2 +: 2]      = {2{lane[DataWidth]}};
      end
      EW32: for (int e = 0; e < 2; e++) begin
        lane = lane_arith(op_i, vxrm_i, signed_i, 64'(opa_i[e*32 +: 32]),
                          64'(opb_i[e*32 +: 32]), 7'd32);
        result_o[e*32 +: 32] = lane[31:0];
        sat_o[e*4 +: 4]      = {4{lane[DataWidth]}};
      end
      EW64: begin
        lane     = lane_arith(op_i, vxrm_i, signed_i, opa_i, opb_i, 7'd64);
        result_o = lane[DataWidth-1:0];
        sat_o    = {StrbWidth{lane[DataWidth]}};
      end
      default: result_o = '0;
    endcase
  end

endmodule

// ==== simd_alu_compare.sv ====
// Per-lane less/equal evaluation, min/max selection and compare result packing
`timescale 1ns/1ps

module simd_alu_compare import simd_alu_pkg::*; (
  input  alu_op_e op_i,
  input  vew_e    vew_i,
  input  logic    signed_i,
  input  elen_t   opa_i,
  input  elen_t   opb_i,
  output elen_t   result_o
);

  // One element of w bits, b against a
  function automatic elen_t lane_cmp(alu_op_e op, logic sgn, elen_t a, elen_t b,
                                     logic [6:0] w);
    logic [DataWidth:0] a_x;
    logic [DataWidth:0] b_x;
    logic               less;
    logic               equal;
    elen_t              res;
    a_x   = lane_ext(a, w, sgn);
    b_x   = lane_ext(b, w, sgn);
    less  = $signed(b_x) < $signed(a_x);
    equal = a == b;
    res   = '0;
    case (op)
      VMINU, VMIN:   res = less ? b : a;
      VMAXU, VMAX:   res = less ? a : b;
      VMSEQ:         res = 64'(equal);
      VMSNE:         res = 64'(!equal);
      VMSLTU, VMSLT: res = 64'(less);
      VMSLEU, VMSLE: res = 64'(less | equal);
      VMSGTU, VMSGT: res = 64'(!(less | equal));
      default:       res = '0;
    endcase
    return res;
  endfunction

  ////////////////////////////////////////
  // Lane split by element width
  ////////////////////////////////////////

  always_comb begin
    elen_t lane;
    result_o = '0;
    lane     = '0;
    unique case (vew_i)
      EW8: for (int e = 0; e < 8; e++) begin
        lane = lane_cmp(op_i, signed_i, 64'(opa_i[e*8 +: 8]), 64'(opb_i[e*8 +: 8]), 7'd8);
        result_o[e*8 +: 8] = lane[7:0];
      end
      EW16: for (int e = 0; e < 4; e++) begin
        lane = lane_cmp(op_i, signed_i, 64'(opa_i[e*16 +: 16]), 64'(opb_i[e*16 +: 16]),
                        7'd16);
        result_o[e*16 +: 16] = lane[15:0];
      end
      EW32: for (int e = 0; e < 2; e++) begin
        lane = lane_cmp(op_i, signed_i, 64'(opa_i[e*32 +: 32]), 64'(opb_i[e*32 +: 32]),
                        7'd32);
        result_o[e*32 +: 32] = lane[31:0];
      end
      EW64: begin
        result_o = lane_cmp(op_i, signed_i, opa_i, opb_i, 7'd64);
      end
      default: result_o = '0;
    endcase
  end

endmodule

// ==== simd_alu_logic_shift.sv ====
// Bitwise logic on the whole word and per-lane logical and arithmetic shifts
`timescale 1ns/1ps

module simd_alu_logic_shift import simd_alu_pkg::*; (
  input  alu_op_e op_i,
  input  vew_e    vew_i,
  input  elen_t   opa_i,
  input  elen_t   opb_i,
  output elen_t   result_o
);

  // Shift b by the low log2(w) bits of a
  function automatic elen_t lane_shift(alu_op_e op, elen_t a, elen_t b, logic [6:0] w);
    logic [5:0]         sh;
    logic [DataWidth:0] b_x;
    elen_t              res;
    sh  = a[5:0] & 6'(w - 7'd1);
    b_x = lane_ext(b, w, op == VSRA);
    case (op)
      VSLL:    res = b << sh;
      VSRL:    res = b >> sh;
      VSRA:    res = elen_t'($signed(b_x) >>> sh);
      default: res = '0;
    endcase
    return res;
  endfunction

  always_comb begin
    elen_t lane;
    result_o = '0;
    lane     = '0;
    case (op_i)
      VAND: result_o = opa_i & opb_i;
      VOR:  result_o = opa_i | opb_i;
      VXOR: result_o = opa_i ^ opb_i;
      VSLL, VSRL, VSRA: begin
        unique case (vew_i)
          EW8: for (int e = 0; e < 8; e++) begin
            lane = lane_shift(op_i, 64'(opa_i[e*8 +: 8]), 64'(opb_i[e*8 +: 8]), 7'd8);
            result_o[e*8 +: 8] = lane[7:0];
          end
          EW16: for (int e = 0; e < 4; e++) begin
            lane = lane_shift(op_i, 64'(opa_i[e*16 +: 16]), 64'(opb_i[e*16 +: 16]), 7'd16);
            result_o[e*16 +: 16] = lane[15:0];
          end
          EW32: for (int e = 0; e < 2; e++) begin
            lane = lane_shift(op_i, 64'(opa_i[e*32 +: 32]), 64'(opb_i[e*32 +: 32]), 7'd32);
            result_o[e*32 +: 32] = lane[31:0];
          end
          EW64: result_o = lane_shift(op_i, opa_i, opb_i, 7'd64);
          default: result_o = '0;
        endcase
      end
      default: result_o = '0;
    endcase
  end

endmodule

// ==== simd_alu_operand_stage.sv ====
// Input register stage with opcode to unit and signedness decode
`timescale 1ns/1ps

module simd_alu_operand_stage import simd_alu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      valid_i,
  input  alu_op_e   op_i,
  input  vew_e      vew_i,
  input  vxrm_e     vxrm_i,
  input  elen_t     operand_a_i,
  input  elen_t     operand_b_i,
  output logic      valid_o,
  output alu_op_e   op_o,
  output vew_e      vew_o,
  output vxrm_e     vxrm_o,
  output elen_t     opa_o,
  output elen_t     opb_o,
  output alu_unit_e unit_o,
  output logic      signed_o
);

  alu_unit_e unit_d;
  logic      signed_d;

  // Owning unit of each opcode
  always_comb begin
    case (op_i)
      VAND, VOR, VXOR, VSLL, VSRL, VSRA: unit_d = UNIT_LOGIC;
      VADD, VSUB, VSADDU, VSADD, VSSUBU, VSSUB,
      VAADDU, VAADD:                     unit_d = UNIT_ARITH;
      default:                           unit_d = UNIT_CMP;
    endcase
  end

  assign signed_d = op_i inside {VSADD, VSSUB, VAADD, VSRA, VMIN, VMAX, VMSLT, VMSLE, VMSGT};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Loads only with a new operation
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      op_o     <= op_i;
      vew_o    <= vew_i;
      vxrm_o   <= vxrm_i;
      opa_o    <= operand_a_i;
      opb_o    <= operand_b_i;
      unit_o   <= unit_d;
      signed_o <= signed_d;
    end
  end

endmodule

// ==== simd_alu_pkg.sv ====
// Datapath widths, word types, opcode/width/rounding/unit enums and lane sign extension
package simd_alu_pkg;

  ////////////////////////////////////////
  // Widths and word types
  ////////////////////////////////////////

  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [DataWidth-1:0] elen_t;
  typedef logic [StrbWidth-1:0] strb_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Fixed-point rounding for averaging add
  typedef enum logic [1:0] {
    RNU,
    RNE,
    RDN,
    ROD
  } vxrm_e;

  typedef enum logic [4:0] {
    VAND, VOR, VXOR,
    VADD, VSUB,
    VSADDU, VSADD, VSSUBU, VSSUB,
    VAADDU, VAADD,
    VSLL, VSRL, VSRA,
    VMINU, VMIN, VMAXU, VMAX,
    VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE, VMSGTU, VMSGT
  } alu_op_e;

  typedef enum logic [1:0] {
    UNIT_LOGIC,
    UNIT_ARITH,
    UNIT_CMP
  } alu_unit_e;

  // Widen a w-bit element, zero above w on entry, to DataWidth+1 bits
  function automatic logic [DataWidth:0] lane_ext(elen_t x, logic [6:0] w, logic sgn);
    logic [DataWidth:0] hi_mask;
    hi_mask = {(DataWidth + 1){1'b1}} << w;
    return {1'b0, x} | ({(DataWidth + 1){sgn & x[6'(w - 7'd1)]}} & hi_mask);
  endfunction

endpackage

// ==== simd_alu_result_stage.sv ====
// Unit result select, saturation flag gating and output registers
`timescale 1ns/1ps

module simd_alu_result_stage import simd_alu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      valid_i,
  input  alu_unit_e unit_i,
  input  elen_t     logic_res_i,
  input  elen_t     arith_res_i,
  input  elen_t     cmp_res_i,
  input  strb_t     arith_sat_i,
  output logic      valid_o,
  output elen_t     result_o,
  output strb_t     vxsat_o
);

  elen_t res_d;
  strb_t sat_d;

  // Only arithmetic results carry saturation
  always_comb begin
    case (unit_i)
      UNIT_LOGIC: begin
        res_d = logic_res_i;
        sat_d = '0;
      end
      UNIT_ARITH: begin
        res_d = arith_res_i;
        sat_d = arith_sat_i;
      end
      default: begin
        res_d = cmp_res_i;
        sat_d = '0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      vxsat_o  <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o <= res_d;
        vxsat_o  <= sat_d;
      end
    end
  end

endmodule

// ==== simd_alu_top.sv ====
// Two-stage SIMD vector ALU top level with operand, unit and result stages
`timescale 1ns/1ps

module simd_alu_top import simd_alu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    valid_i,
  input  alu_op_e op_i,
  input  vew_e    vew_i,
  input  vxrm_e   vxrm_i,
  input  elen_t   operand_a_i,
  input  elen_t   operand_b_i,
  output logic    valid_o,
  output elen_t   result_o,
  output strb_t   vxsat_o
);

  // Stage 1 state
  logic      s1_valid;
  alu_op_e   s1_op;
  vew_e      s1_vew;
  vxrm_e     s1_vxrm;
  elen_t     s1_opa;
  elen_t     s1_opb;
  alu_unit_e s1_unit;
  logic      s1_signed;

  // Unit results
  elen_t     logic_res;
  elen_t     arith_res;
  strb_t     arith_sat;
  elen_t     cmp_res;

  simd_alu_operand_stage u_operand_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .vxrm_i      (vxrm_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (s1_valid),
    .op_o        (s1_op),
    .vew_o       (s1_vew),
    .vxrm_o      (s1_vxrm),
    .opa_o       (s1_opa),
    .opb_o       (s1_opb),
    .unit_o      (s1_unit),
    .signed_o    (s1_signed)
  );

  simd_alu_logic_shift u_logic_shift (
    .op_i     (s1_op),
    .vew_i    (s1_vew),
    .opa_i    (s1_opa),
    .opb_i    (s1_opb),
    .result_o (logic_res)
  );

  simd_alu_arith u_arith (
    .op_i     (s1_op),
    .vew_i    (s1_vew),
    .vxrm_i   (s1_vxrm),
    .signed_i (s1_signed),
    .opa_i    (s1_opa),
    .opb_i    (s1_opb),
    .result_o (arith_res),
    .sat_o    (arith_sat)
  );

  simd_alu_compare u_compare (
    .op_i     (s1_op),
    .vew_i    (s1_vew),
    .signed_i (s1_signed),
    .opa_i    (s1_opa),
    .opb_i    (s1_opb),
    .result_o (cmp_res)
  );

  simd_alu_result_stage u_result_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (s1_valid),
    .unit_i      (s1_unit),
    .logic_res_i (logic_res),
    .arith_res_i (arith_res),
    .cmp_res_i   (cmp_res),
    .arith_sat_i (arith_sat),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o)
  );

endmodule

// ==== src.f ====
+incdir+.
simd_alu_pkg.sv
simd_alu_operand_stage.sv
simd_alu_logic_shift.sv
simd_alu_arith.sv
simd_alu_compare.sv
simd_alu_result_stage.sv
simd_alu_top.sv
tb_simd_alu.sv

// ==== tb_simd_alu_model.svh ====
// Reference functions for the expected result and per-byte saturation flags of the SIMD ALU
`ifndef TB_SIMD_ALU_MODEL_SVH
`define TB_SIMD_ALU_MODEL_SVH

// Low w bits of x as a signed number
function automatic logic signed [65:0] sign_extend(logic [63:0] x, int w);
  logic signed [65:0] t;
  t = $signed({2'b00, x} << (66 - w));
  return t >>> (66 - w);
endfunction

// One element of w bits, b against a, returns {saturated, value}
function automatic logic [64:0] lane_expected(alu_op_e op, vxrm_e rm, logic [63:0] a,
                                              logic [63:0] b, int w);
  logic [63:0]        mask;
  logic signed [65:0] ua;
  logic signed [65:0] ub;
  logic signed [65:0] sa;
  logic signed [65:0] sb;
  logic signed [65:0] va;
  logic signed [65:0] vb;
  logic signed [65:0] r;
  logic signed [65:0] umax;
  logic signed [65:0] smax;
  logic signed [65:0] smin;
  logic signed [65:0] lo;
  logic signed [65:0] hi;
  logic               sgn;
  logic               sat;
  logic               less;
  logic               dropped;
  logic               kept;
  int                 sh;
  mask = {64{1'b1}} >> (64 - w);
  ua   = $signed({2'b00, a & mask});
  ub   = $signed({2'b00, b & mask});
  sa   = sign_extend(a, w);
  sb   = sign_extend(b, w);
  sgn  = op inside {VSADD, VSSUB, VAADD, VSRA, VMIN, VMAX, VMSLT, VMSLE, VMSGT};
  va   = sgn ? sa : ua;
  vb   = sgn ? sb : ub;
  umax = $signed({2'b00, mask});
  smax = $signed({2'b00, mask >> 1});
  smin = -smax - 66'sd1;
  sh   = int'(a & 64'(w - 1));
  less = vb < va;
  sat  = 1'b0;
  r    = '0;
  case (op)
    VAND:                         r = ua & ub;
    VOR:                          r = ua | ub;
    VXOR:                         r = ua ^ ub;
    VADD, VSADDU, VSADD:          r = va + vb;
    VSUB, VSSUBU, VSSUB:          r = vb - va;
    VAADDU, VAADD: begin
      r       = va + vb;
      dropped = r[0];
      r       = r >>> 1;
      kept    = r[0];
      if (rm == RNU && dropped) r = r + 66'sd1;
      if (rm == RNE && dropped && kept) r = r + 66'sd1;
      if (rm == ROD && dropped && !kept) r[0] = 1'b1;
    end
    VSLL:                         r = ub << sh;
    VSRL:                         r = ub >> sh;
    VSRA:                         r = sb >>> sh;
    VMINU, VMIN:                  r = less ? vb : va;
    VMAXU, VMAX:                  r = less ? va : vb;
    VMSEQ:                        r = {65'd0, ua == ub};
    VMSNE:                        r = {65'd0, ua != ub};
    VMSLTU, VMSLT:                r = {65'd0, less};
    VMSLEU, VMSLE:                r = {65'd0, less || ua == ub};
    default:                      r = {65'd0, !less && ua != ub};
  endcase
  // Clamp to the element range
  if (op inside {VSADDU, VSADD, VSSUBU, VSSUB}) begin
    lo = sgn ? smin : 66'sd0;
    hi = sgn ? smax : umax;
    if (r > hi) begin
      r   = hi;
      sat = 1'b1;
    end else if (r < lo) begin
      r   = lo;
      sat = 1'b1;
    end
  end
  return {sat, r[63:0] & mask};
endfunction

// Whole word, returns {vxsat, result}
function automatic logic [71:0] expected_word(alu_op_e op, vew_e vew, vxrm_e rm,
                                              logic [63:0] a, logic [63:0] b);
  int          w;
  logic [63:0] mask;
  logic [63:0] res;
  logic [7:0]  sat;
  logic [64:0] lane;
  w    = 8 << int'(vew);
  mask = {64{1'b1}} >> (64 - w);
  res  = '0;
  sat  = '0;
  for (int e = 0; e < 64 / w; e++) begin
    lane = lane_expected(op, rm, (a >> (e * w)) & mask, (b >> (e * w)) & mask, w);
    res  = res | (lane[63:0] << (e * w));
    for (int k = 0; k < w / 8; k++) begin
      sat[e * (w / 8) + k] = lane[64];
    end
  end
  return {sat, res};
endfunction

`endif

// ==== tb_simd_alu.sv ====
// Testbench for the SIMD ALU with stimulus, expected-value queue, assertions and watchdog
`timescale 1ns/1ps

module tb_simd_alu import simd_alu_pkg::*; ();

  `include "tb_simd_alu_model.svh"

  localparam int num_plain      = 18 * 4 * 4;
  localparam int num_sat        = 6 * 4 * 20;
  localparam int num_avg        = 2 * 4 * 4 * 10;
  localparam int num_burst      = 100;
  localparam int num_tests      = num_plain + num_sat + num_avg + num_burst;
  localparam int timeout_cycles = num_tests * 20 + 200;

  localparam alu_op_e plain_ops [18] = '{VAND, VOR, VXOR, VSLL, VSRL, VSRA,
                                         VMINU, VMIN, VMAXU, VMAX, VMSEQ, VMSNE,
                                         VMSLTU, VMSLT, VMSLEU, VMSLE, VMSGTU, VMSGT};
  localparam alu_op_e sat_ops [6]    = '{VADD, VSUB, VSADDU, VSADD, VSSUBU, VSSUB};
  localparam alu_op_e avg_ops [2]    = '{VAADDU, VAADD};

  logic        clk_i;
  logic        rst_n_i;
  logic        valid_i;
  alu_op_e     op_i;
  vew_e        vew_i;
  vxrm_e       vxrm_i;
  elen_t       operand_a_i;
  elen_t       operand_b_i;
  logic        valid_o;
  elen_t       result_o;
  strb_t       vxsat_o;

  logic [71:0] exp_q [$];
  logic [63:0] head_result;
  logic [7:0]  head_sat;
  int          q_count = 0;
  int          errors  = 0;
  int          checked = 0;
  integer      seed    = 67234;

  simd_alu_top DUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .vxrm_i      (vxrm_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Expected values and checks
  ////////////////////////////////////////

  // Pop on output, push on input, then publish the new head
  always @(posedge clk_i) begin
    if (valid_o && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      checked++;
    end
    if (valid_i) begin
      exp_q.push_back(expected_word(op_i, vew_i, vxrm_i, operand_a_i, operand_b_i));
    end
    if (exp_q.size() > 0) begin
      head_result <= exp_q[0][63:0];
      head_sat    <= exp_q[0][71:64];
    end
    q_count <= exp_q.size();
  end

  result_matches: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> result_o == head_result)
    else begin
      $display("Error: result_o = %h, expected %h", $sampled(result_o), $sampled(head_result));
      errors++;
    end

  vxsat_matches: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> vxsat_o == head_sat)
    else begin
      $display("Error: vxsat_o = %h, expected %h", $sampled(vxsat_o), $sampled(head_sat));
      errors++;
    end

  output_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> q_count > 0)
    else begin
      $display("valid_o went high with no operation outstanding");
      errors++;
    end

  latency_two: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o == $past(valid_i, 2))
    else begin
      $display("Error: valid_o = %h, expected %h", $sampled(valid_o), $past(valid_i, 2));
      errors++;
    end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic send_op(alu_op_e op, vew_e vew, vxrm_e rm, elen_t a, elen_t b);
    @(posedge clk_i);
    valid_i     <= 1'b1;
    op_i        <= op;
    vew_i       <= vew;
    vxrm_i      <= rm;
    operand_a_i <= a;
    operand_b_i <= b;
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(posedge clk_i);
      valid_i <= 1'b0;
    end
  endtask

  function automatic elen_t random_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Same element in every lane
  function automatic elen_t replicate(elen_t elem, vew_e vew);
    int    w;
    elen_t word;
    w    = 8 << int'(vew);
    word = '0;
    for (int e = 0; e < 64 / w; e++) begin
      word = word | ((elem & ({64{1'b1}} >> (64 - w))) << (e * w));
    end
    return word;
  endfunction

  // 0 zero, 1 all ones, 2 signed max, 3 signed min
  function automatic elen_t edge_word(int k, vew_e vew);
    elen_t mask;
    mask = {64{1'b1}} >> (64 - (8 << int'(vew)));
    case (k)
      0:       return '0;
      1:       return '1;
      2:       return replicate(mask >> 1, vew);
      default: return replicate(mask ^ (mask >> 1), vew);
    endcase
  endfunction

  initial begin
    int    sent;
    int    len;
    vew_e  vew;
    elen_t word_a;
    valid_i     = 1'b0;
    op_i        = VAND;
    vew_i       = EW8;
    vxrm_i      = RNU;
    operand_a_i = '0;
    operand_b_i = '0;
    rst_n_i     = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Idle outputs before the first operation
    @(negedge clk_i);
    reset_valid: assert (valid_o == 1'b0) else begin
      $display("Error: valid_o = %h after reset, expected 0", valid_o);
      errors++;
    end
    reset_result: assert (result_o == '0) else begin
      $display("Error: result_o = %h after reset, expected 0", result_o);
      errors++;
    end
    reset_vxsat: assert (vxsat_o == '0) else begin
      $display("Error: vxsat_o = %h after reset, expected 0", vxsat_o);
      errors++;
    end

    for (int v = 0; v < 4; v++) begin
      vew = vew_e'(2'(v));
      foreach (plain_ops[i]) begin
        // Equal operands reach the equality paths
        word_a = random_word();
        send_op(plain_ops[i], vew, RNU, word_a, word_a);
        repeat (3) send_op(plain_ops[i], vew, RNU, random_word(), random_word());
      end
    end

    // Edge operands in every pairing
    for (int v = 0; v < 4; v++) begin
      vew = vew_e'(2'(v));
      foreach (sat_ops[i]) begin
        for (int j = 0; j < 16; j++) begin
          send_op(sat_ops[i], vew, RNU, edge_word(j % 4, vew), edge_word(j / 4, vew));
        end
        repeat (4) send_op(sat_ops[i], vew, RNU, random_word(), random_word());
      end
    end

    for (int v = 0; v < 4; v++) begin
      vew = vew_e'(2'(v));
      foreach (avg_ops[i]) begin
        for (int m = 0; m < 4; m++) begin
          // Dropped bit set, kept bit set then clear
          send_op(avg_ops[i], vew, vxrm_e'(2'(m)), replicate(64'd1, vew), replicate(64'd2, vew));
          send_op(avg_ops[i], vew, vxrm_e'(2'(m)), replicate(64'd1, vew), '0);
          repeat (8) send_op(avg_ops[i], vew, vxrm_e'(2'(m)), random_word(), random_word());
        end
      end
    end

    // Bursts of random operations with idle gaps
    sent = 0;
    while (sent < num_burst) begin
      len = 1 + int'($unsigned($random(seed)) % 6);
      for (int k = 0; k < len && sent < num_burst; k++) begin
        send_op(alu_op_e'(5'($unsigned($random(seed)) % 26)), vew_e'(2'($random(seed))),
                vxrm_e'(2'($random(seed))), random_word(), random_word());
        sent++;
      end
      idle_cycles(1 + int'($unsigned($random(seed)) % 3));
    end

    idle_cycles(3);
    while (q_count != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);

    if (checked != num_tests) begin
      $display("Only %0d of %0d results came out of the DUT", checked, num_tests);
      errors++;
    end
    $display("Checked %0d results, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (timeout_cycles) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("Test failed");
    $finish;
  end

endmodule
